//--- source/core_config.svh
/*
 * Build constants for the accumulator core
 *  - Program counter, instruction and accumulator widths
 *  - Fetch queue depth
 *  - First fetch address after reset
 */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Word address, not byte address
`define CORE_PC_WIDTH     12
`define CORE_INSTR_WIDTH  16
`define CORE_DATA_WIDTH   16

// Must be a power of two
`define CORE_QUEUE_DEPTH  4
`define CORE_RESET_PC     0

`endif

//--- source/core_pkg.sv
/*
 * Shared types for the accumulator core
 *  - Vector types for PC, instruction word and accumulator
 *  - Opcode encoding and fetch FSM states
 */
`default_nettype none
`include "core_config.svh"

package core_pkg;

   typedef logic [`CORE_PC_WIDTH-1:0]    pc_t;     // Instruction word address
   typedef logic [`CORE_INSTR_WIDTH-1:0] instr_t;  // Opcode in the top nibble
   typedef logic [`CORE_DATA_WIDTH-1:0]  data_t;

   localparam int OPCODE_W  = 4;
   localparam int OPERAND_W = `CORE_INSTR_WIDTH - OPCODE_W;

   // Codes not listed here execute as NOP
   typedef enum logic [OPCODE_W-1:0] {
      NOP  = 4'd0,
      ADDI = 4'd1,
      SUBI = 4'd2,
      JMP  = 4'd3,
      JZ   = 4'd4,
      OUT  = 4'd5
   } opcode_e;

   typedef enum logic [1:0] {IDLE, BUSY, HOLD} fetch_state_e;

endpackage : core_pkg

`default_nettype wire

//--- source/core_top.sv
/*
 * Accumulator core top level
 *  - Fetch unit on the Wishbone instruction port
 *  - Fetch queue between front end and back end
 *  - Execute unit with commit trace and value port
 */
`default_nettype none

module core_top (
   input  logic             clk_i,
   input  logic             rst_i,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output core_pkg::pc_t    wb_adr_o,
   input  core_pkg::instr_t wb_dat_i,
   input  logic             wb_ack_i,
   output logic             commit_v_o,
   output core_pkg::pc_t    commit_pc_o,
   output logic             out_v_o,
   output core_pkg::data_t  out_data_o,
   input  logic             out_ready_i
);
   import core_pkg::*;

   logic   push_v, push_ready;
   pc_t    push_pc;
   instr_t push_instr;
   logic   head_v, pop;
   pc_t    head_pc;
   instr_t head_instr;
   logic   redirect_v;   // Also clears the queue
   pc_t    redirect_pc;

   fetch_unit fe (
      .clk_i, .rst_i,
      .wb_cyc_o, .wb_stb_o, .wb_adr_o, .wb_dat_i, .wb_ack_i,
      .push_v_o(push_v), .push_pc_o(push_pc), .push_instr_o(push_instr),
      .push_ready_i(push_ready),
      .redirect_v_i(redirect_v), .redirect_pc_i(redirect_pc)
   );

   fetch_queue fe_queue (
      .clk_i, .rst_i, .clr_i(redirect_v),
      .push_v_i(push_v), .push_pc_i(push_pc), .push_instr_i(push_instr),
      .push_ready_o(push_ready),
      .head_v_o(head_v), .head_pc_o(head_pc), .head_instr_o(head_instr),
      .pop_i(pop)
   );

   exec_unit be (
      .clk_i, .rst_i,
      .head_v_i(head_v), .head_pc_i(head_pc), .head_instr_i(head_instr), .pop_o(pop),
      .redirect_v_o(redirect_v), .redirect_pc_o(redirect_pc),
      .commit_v_o, .commit_pc_o,
      .out_v_o, .out_data_o, .out_ready_i
   );

endmodule : core_top

`default_nettype wire

//--- source/exec_unit.sv
/*
 * Execute unit
 *  - Decode and execute of the queue head, accumulator
 *  - Jump redirect to the front end
 *  - Commit trace and valid/ready value port
 */
`default_nettype none

module exec_unit (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             head_v_i,
   input  core_pkg::pc_t    head_pc_i,
   input  core_pkg::instr_t head_instr_i,
   output logic             pop_o,
   output logic             redirect_v_o,
   output core_pkg::pc_t    redirect_pc_o,
   output logic             commit_v_o,
   output core_pkg::pc_t    commit_pc_o,
   output logic             out_v_o,
   output core_pkg::data_t  out_data_o,
   input  logic             out_ready_i
);
   import core_pkg::*;

   opcode_e              opcode;
   logic [OPERAND_W-1:0] operand;
   data_t                acc_q, acc_d;
   logic                 taken;
   logic                 is_out;
   logic                 port_free;

   always_comb begin
      opcode  = opcode_e'(head_instr_i[$bits(instr_t)-1 -: OPCODE_W]);
      operand = head_instr_i[OPERAND_W-1:0];
      acc_d   = acc_q;
      taken   = 1'b0;
      is_out  = 1'b0;
      case (opcode)
         ADDI: acc_d = acc_q + data_t'(operand);   // Wraps
         SUBI: acc_d = acc_q - data_t'(operand);
         JMP:  taken = 1'b1;
         JZ:   taken = (acc_q == '0);              // Value before this instruction
         OUT:  is_out = 1'b1;
         default: ;
      endcase
   end

   // Value port can take a new word this cycle
   assign port_free = !out_v_o || out_ready_i;

   // Nothing pops in the cycle the redirect goes out
   assign pop_o = head_v_i && !redirect_v_o && (!is_out || port_free);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         acc_q        <= '0;
         commit_v_o   <= 1'b0;
         redirect_v_o <= 1'b0;
         out_v_o      <= 1'b0;
      end else begin
         commit_v_o   <= pop_o;
         redirect_v_o <= pop_o && taken;
         if (pop_o)
            acc_q <= acc_d;
         if (pop_o && is_out)
            out_v_o <= 1'b1;
         else if (out_ready_i)
            out_v_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         commit_pc_o   <= head_pc_i;
         redirect_pc_o <= pc_t'(operand);
      end
      if (pop_o && is_out)
         out_data_o <= acc_q;
   end

   a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      out_v_o && !out_ready_i |=> out_v_o && $stable(out_data_o));

endmodule : exec_unit

`default_nettype wire

//--- source/fetch_queue.sv
/*
 * Fetch queue
 *  - Circular buffer of PC and instruction pairs
 *  - Synchronous clear that wins over a push
 */
`default_nettype none
`include "core_config.svh"

module fetch_queue #(
   parameter int DEPTH = `CORE_QUEUE_DEPTH
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             clr_i,
   input  logic             push_v_i,
   input  core_pkg::pc_t    push_pc_i,
   input  core_pkg::instr_t push_instr_i,
   output logic             push_ready_o,
   output logic             head_v_o,
   output core_pkg::pc_t    head_pc_o,
   output core_pkg::instr_t head_instr_o,
   input  logic             pop_i
);
   import core_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   pc_t              pc_mem    [DEPTH];
   instr_t           instr_mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
   logic [PTR_W:0]   count_q;
   logic             do_push;

   assign push_ready_o = (count_q != (PTR_W+1)'(DEPTH));
   assign head_v_o     = (count_q != '0);
   assign head_pc_o    = pc_mem[rd_ptr_q];
   assign head_instr_o = instr_mem[rd_ptr_q];
   assign do_push      = push_v_i && push_ready_o;

   always_ff @(posedge clk_i) begin
      if (rst_i || clr_i) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at DEPTH
         if (pop_i)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         pc_mem[wr_ptr_q]    <= push_pc_i;
         instr_mem[wr_ptr_q] <= push_instr_i;
      end
   end

   a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> head_v_o);

   // When full the write slot is the head entry
   a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      push_v_i && !push_ready_o && !pop_i && !clr_i
      |=> $stable(head_pc_o) && $stable(head_instr_o));

endmodule : fetch_queue

`default_nettype wire

//--- source/fetch_unit.sv
/*
 * Instruction fetch unit
 *  - Read-only Wishbone classic master, one word per bus cycle
 *  - Sequential PC with redirect from the back end
 *  - Words fetched before a redirect are dropped
 */
`default_nettype none
`include "core_config.svh"

module fetch_unit (
   input  logic             clk_i,
   input  logic             rst_i,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output core_pkg::pc_t    wb_adr_o,
   input  core_pkg::instr_t wb_dat_i,
   input  logic             wb_ack_i,
   output logic             push_v_o,
   output core_pkg::pc_t    push_pc_o,
   output core_pkg::instr_t push_instr_o,
   input  logic             push_ready_i,
   input  logic             redirect_v_i,
   input  core_pkg::pc_t    redirect_pc_i
);
   import core_pkg::*;

   fetch_state_e state_q, state_d;
   pc_t          pc_q, pc_d;   // Address on the bus, or of the held word
   pc_t          target_q;     // Redirect seen while the bus was busy
   logic         stale_q;
   instr_t       hold_q;

   always_comb begin
      state_d = state_q;
      pc_d    = pc_q;
      case (state_q)
         IDLE: begin
            state_d = BUSY;
            if (redirect_v_i)
               pc_d = redirect_pc_i;
         end
         BUSY: begin
            if (wb_ack_i) begin
               if (stale_q || redirect_v_i) begin
                  // Wrong-path word, let cyc drop for one cycle
                  state_d = IDLE;
                  pc_d    = redirect_v_i ? redirect_pc_i : target_q;
               end else begin
                  state_d = HOLD;
               end
            end
         end
         HOLD: begin
            if (redirect_v_i) begin
               state_d = BUSY;
               pc_d    = redirect_pc_i;
            end else if (push_ready_i) begin
               state_d = BUSY;
               pc_d    = pc_q + pc_t'(1);
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         pc_q    <= pc_t'(`CORE_RESET_PC);
         stale_q <= 1'b0;
      end else begin
         state_q <= state_d;
         pc_q    <= pc_d;
         if (state_q == BUSY && wb_ack_i)
            stale_q <= 1'b0;
         else if (state_q == BUSY && redirect_v_i)
            stale_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (redirect_v_i)
         target_q <= redirect_pc_i;
      if (state_q == BUSY && wb_ack_i)
         hold_q <= wb_dat_i;
   end

   assign wb_cyc_o     = (state_q == BUSY);
   assign wb_stb_o     = (state_q == BUSY);
   assign wb_adr_o     = pc_q;
   assign push_v_o     = (state_q == HOLD);
   assign push_pc_o    = pc_q;
   assign push_instr_o = hold_q;

   // Slave sees one request per bus cycle
   a_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule : fetch_unit

`default_nettype wire

//--- sources.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/exec_unit.sv
source/core_top.sv
tests/core_mem_model.sv
tests/core_tb.sv

//--- tests/core_mem_model.sv
/*
 * Wishbone classic slave memory for the core testbench
 *  - Read-only, one ack per bus cycle
 *  - Random wait states up to MAX_WAIT
 *  - Contents written by the testbench before reset is released
 */
`default_nettype none
`include "core_config.svh"

module core_mem_model #(
   parameter int MAX_WAIT = 3
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             wb_cyc_i,
   input  logic             wb_stb_i,
   input  core_pkg::pc_t    wb_adr_i,
   output core_pkg::instr_t wb_dat_o,
   output logic             wb_ack_o
);
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;

   instr_t      mem_q [2**`CORE_PC_WIDTH];
   int unsigned wait_q;   // Wait states left before the next ack

   always @(posedge clk_i) begin
      if (rst_i) begin
         wb_ack_o <= 1'b0;
         wait_q   <= $urandom_range(MAX_WAIT, 0);
      end else if (wb_ack_o) begin
         wb_ack_o <= 1'b0;   // Master drops stb in this cycle
      end else if (wb_cyc_i && wb_stb_i) begin
         if (wait_q == 0) begin
            wb_ack_o <= 1'b1;
            wb_dat_o <= mem_q[wb_adr_i];
            wait_q   <= $urandom_range(MAX_WAIT, 0);
         end else begin
            wait_q <= wait_q - 1;
         end
      end
   end

endmodule : core_mem_model

`default_nettype wire

//--- tests/core_tb.sv
/*
 * Testbench for the accumulator core
 *  - Clock, reset and random value-port back-pressure
 *  - Random program of ALU runs, forward jumps and JZ
 *  - Reference walk of the program giving expected commits and values
 *  - Assertions on commit, value and Wishbone ports, watchdog
 */
`default_nettype none
`include "core_config.svh"

module core_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;

   localparam int MAX_WAIT = 3;
   localparam int MEM_WORDS = 2**`CORE_PC_WIDTH;
   localparam int N_BLOCKS = 40;

   logic   clk_i, rst_i, out_ready_i;
   logic   wb_cyc, wb_stb, wb_ack;
   pc_t    wb_adr;
   instr_t wb_dat;
   logic   commit_v_o, out_v_o;
   pc_t    commit_pc_o;
   data_t  out_data_o;

   instr_t prog [MEM_WORDS];
   bit     is_junk [MEM_WORDS];
   pc_t    exp_commits [$];
   data_t  exp_outs [$];
   pc_t    final_pc;
   pc_t    gen_pc;
   data_t  gen_acc;
   bit     seen_commit;
   int     stall_cnt;

   core_top dut (
      .clk_i, .rst_i,
      .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_adr_o(wb_adr),
      .wb_dat_i(wb_dat), .wb_ack_i(wb_ack),
      .commit_v_o, .commit_pc_o,
      .out_v_o, .out_data_o, .out_ready_i
   );

   core_mem_model #(.MAX_WAIT(MAX_WAIT)) mem (
      .clk_i, .rst_i,
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_adr_i(wb_adr),
      .wb_dat_o(wb_dat), .wb_ack_o(wb_ack)
   );

   always #10 clk_i = ~clk_i;

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic put_word(input logic [3:0] op, input logic [11:0] arg);
      prog[gen_pc] = {op, arg};
      if (op == ADDI)
         gen_acc = gen_acc + data_t'(arg);
      else if (op == SUBI)
         gen_acc = gen_acc - data_t'(arg);
      gen_pc = gen_pc + 1;
   endtask

   task automatic put_junk(input int n);
      for (int i = 0; i < n; i++) begin
         prog[gen_pc]    = instr_t'($urandom);
         is_junk[gen_pc] = 1'b1;
         gen_pc          = gen_pc + 1;
      end
   endtask

   task automatic build_program();
      int kind;
      int skip;
      logic [11:0] arg;
      for (int a = 0; a < MEM_WORDS; a++) begin
         prog[a]    = {4'hF, 12'(a)};   // Unused code, acts as NOP
         is_junk[a] = 1'b0;
      end
      is_junk[12'hF00] = 1'b1;   // Target of every untaken JZ
      gen_pc  = pc_t'(`CORE_RESET_PC);
      gen_acc = '0;
      for (int b = 0; b < N_BLOCKS; b++) begin
         kind = $urandom_range(3, 0);
         skip = $urandom_range(3, 1);
         case (kind)
            0: for (int i = 0; i < $urandom_range(6, 2); i++) begin
               arg = 12'($urandom);
               put_word(4'($urandom_range(OUT, ADDI)) == JMP ? OUT :
                        (($urandom_range(2, 0) == 0) ? SUBI : ADDI), arg);
               if ($urandom_range(2, 0) == 0)
                  put_word(OUT, 12'h0);
            end
            1: begin
               put_word(JMP, 12'(gen_pc + 1 + skip));
               put_junk(skip);
            end
            2: begin
               while (gen_acc != 0)   // Clear the accumulator so JZ is taken
                  put_word(SUBI, gen_acc > 16'hFFF ? 12'hFFF : gen_acc[11:0]);
               put_word(JZ, 12'(gen_pc + 1 + skip));
               put_junk(skip);
            end
            default: begin
               if (gen_acc == 0)
                  put_word(ADDI, 12'($urandom_range(4095, 1)));
               put_word(JZ, 12'hF00);
               put_word(OUT, 12'h0);
            end
         endcase
      end
      put_word(OUT, 12'h0);
      put_word(JMP, 12'(gen_pc));   // Jump to itself
      for (int a = 0; a < MEM_WORDS; a++)
         mem.mem_q[a] = prog[a];
   endtask

   task automatic walk_program();
      pc_t    pc;
      data_t  acc;
      instr_t w;
      bit     done;
      pc   = pc_t'(`CORE_RESET_PC);
      acc  = '0;
      done = 1'b0;
      while (!done) begin
         w = prog[pc];
         exp_commits.push_back(pc);
         case (w[15:12])
            ADDI: begin
               acc = acc + data_t'(w[11:0]);
               pc  = pc + 1;
            end
            SUBI: begin
               acc = acc - data_t'(w[11:0]);
               pc  = pc + 1;
            end
            OUT: begin
               exp_outs.push_back(acc);
               pc = pc + 1;
            end
            JZ:   pc = (acc == 0) ? pc_t'(w[11:0]) : pc + 1;
            JMP: begin
               if (pc_t'(w[11:0]) == pc) begin
                  final_pc = pc;
                  done     = 1'b1;
               end
               pc = pc_t'(w[11:0]);
            end
            default: pc = pc + 1;
         endcase
      end
   endtask

   // Random low stretches on the value port, long ones fill the fetch queue
   always @(posedge clk_i) begin
      #1;
      if (stall_cnt > 0) begin
         out_ready_i = 1'b0;
         stall_cnt   = stall_cnt - 1;
      end else if ($urandom_range(7, 0) == 0) begin
         out_ready_i = 1'b0;
         stall_cnt   = $urandom_range(20, 0);
      end else begin
         out_ready_i = 1'b1;
      end
   end

   always @(posedge clk_i) begin
      pc_t exp_pc;
      if (!rst_i && commit_v_o) begin
         exp_pc = (exp_commits.size() > 0) ? exp_commits.pop_front() : final_pc;
         if (!seen_commit)
            a_first_pc: assert (commit_pc_o == pc_t'(`CORE_RESET_PC))
               else report_error($sformatf("first commit at PC %0h", commit_pc_o));
         seen_commit = 1'b1;
         a_commit_pc: assert (commit_pc_o == exp_pc)
            else report_error($sformatf("commit PC %0h, expected %0h", commit_pc_o, exp_pc));
         a_no_junk: assert (!is_junk[commit_pc_o])
            else report_error($sformatf("junk word at PC %0h committed", commit_pc_o));
      end
   end

   always @(posedge clk_i) begin
      if (!rst_i && out_v_o && out_ready_i) begin
         a_out_expected: assert (exp_outs.size() > 0)
            else report_error("value received beyond the expected sequence");
         a_out_value: assert (out_data_o == exp_outs[0])
            else report_error($sformatf("value %0h, expected %0h", out_data_o, exp_outs[0]));
         void'(exp_outs.pop_front());
      end
   end

   a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      out_v_o && !out_ready_i |=> out_v_o && $stable(out_data_o))
      else report_error("out_data_o changed while the value port was stalled");

   a_adr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
      else report_error("wb_adr_o changed before ack");

   a_cyc_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_cyc == wb_stb)
      else report_error("wb_cyc_o and wb_stb_o differ");

   a_cyc_drop: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_ack |=> !wb_cyc)
      else report_error("bus cycle still open in the cycle after ack");

   initial begin
      longint limit;
      void'($urandom(74572));
      clk_i       = 1'b0;
      rst_i       = 1'b1;
      out_ready_i = 1'b0;
      stall_cnt   = 0;
      seen_commit = 1'b0;
      build_program();
      walk_program();
      limit = (longint'(exp_commits.size()) * (MAX_WAIT + 10) + 20) * 20;
      fork
         begin
            #(limit * 1ns);
            report_error("watchdog expired, the core stopped committing");
         end
      join_none
      repeat (2) @(posedge clk_i);
      #1 rst_i = 1'b0;
      a_reset_low: assert (!commit_v_o && !out_v_o)
         else report_error("commit or value port active right after reset");
      while (exp_outs.size() > 0 || exp_commits.size() > 0)
         @(posedge clk_i);
      repeat (4) @(posedge clk_i);   // Room for a stray value after the last one
      $display("Regression passed");
      $finish;
   end

endmodule : core_tb

`default_nettype wire
